// File: filelist.f
+incdir+.
ltssmPkg.sv
linkParamRegs.sv
linkStateSequencer.sv
lpifStateMachine.sv
pipeRateMap.sv
mainLtssm.sv
ltssmAssert.sv
tbMainLtssm.sv

// File: linkParamRegs.sv
`timescale 1ns/10ps

module linkParamRegs
    import ltssmPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        forceDetect,
    input  paramWrite_t wr,
    output linkParams_t params
);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            params <= '0;
        end
        else if (forceDetect)
        begin
            params <= '0;
        end
        else
        begin
            if (wr.laneWr)
                params.laneCount <= wr.laneCount;

            // tx side owns the link number when both write together
            if (wr.linkTxWr)
                params.linkNumber <= wr.linkTx;
            else if (wr.linkRxWr)
                params.linkNumber <= wr.linkRx;

            if (wr.rateWr)
                params.rateId <= wr.rateId;

            if (wr.upConfigureWr)
                params.upConfigure <= wr.upConfigure;
        end
    end

endmodule

// File: linkStateSequencer.sv
`timescale 1ns/10ps

module linkStateSequencer
    import ltssmPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        forceDetect,
    input  lpifState_e  lpifState,
    input  sideReport_t txReport,
    input  sideReport_t rxReport,
    output substate_e   substate,
    output logic        linkUp,
    output logic        startSend16
);

    `include "ltssm_cfg.svh"

    substate_e nextSubstate;
    logic      wasL0;
    logic      quietReq;
    logic      inTraining;

    function automatic logic reports(input sideReport_t r, input substate_e s);
        return r.finish && (r.gotoState == s);
    endfunction

    assign quietReq = reports(txReport, detectQuiet) || reports(rxReport, detectQuiet);
    assign inTraining = (substate >= detectActive) && (substate <= configurationIdle);

    always_comb
    begin
        nextSubstate = substate;
        case (lpifState)
            lpifReset:
            begin
                case (substate)
                    detectQuiet:
                        if (reports(rxReport, detectActive))
                            nextSubstate = detectActive;
                    detectActive:
                        if (reports(txReport, pollingActive) && reports(rxReport, pollingActive))
                            nextSubstate = pollingActive;
                    pollingActive:
                        if (reports(txReport, pollingConfiguration)
                            || reports(rxReport, pollingConfiguration))
                            nextSubstate = pollingConfiguration;
                    pollingConfiguration:
                        if (reports(txReport, configurationLinkWidthStart)
                            && reports(rxReport, configurationLinkWidthStart))
                            nextSubstate = configurationLinkWidthStart;
                    configurationLinkWidthStart:
                        if (reports(rxReport, configurationLinkWidthAccept))
                            nextSubstate = configurationLinkWidthAccept;
                    configurationLinkWidthAccept:
                    begin
                        // downstream waits on its tx side alone
                        if (reports(txReport, configurationLanenumWait)
                            && (`LTSSM_DEVICE_TYPE == 0
                                || reports(rxReport, configurationLanenumWait)))
                            nextSubstate = configurationLanenumWait;
                    end
                    configurationLanenumWait:
                        if (reports(rxReport, configurationLanenumAccept))
                            nextSubstate = configurationLanenumAccept;
                    configurationLanenumAccept:
                        if (reports(rxReport, configurationComplete))
                            nextSubstate = configurationComplete;
                    configurationComplete:
                        if (reports(txReport, configurationIdle)
                            && reports(rxReport, configurationIdle))
                            nextSubstate = configurationIdle;
                    configurationIdle:
                        if (reports(txReport, L0))
                            nextSubstate = L0;
                    L0:
                    begin
                        // first L0 cycle gives the lpif a chance to go active
                        if (wasL0)
                            nextSubstate = detectQuiet;
                    end
                    default:
                        nextSubstate = detectQuiet;
                endcase

                // forward moves win over a quiet request
                if (inTraining && (nextSubstate == substate) && quietReq)
                    nextSubstate = detectQuiet;
            end
            lpifRetrain:
            begin
                case (substate)
                    L0:
                        if (wasL0)
                            nextSubstate = recoveryRcvrLock;
                    recoveryRcvrLock:
                        if (reports(rxReport, recoveryRcvrCfg))
                            nextSubstate = recoveryRcvrCfg;
                    recoveryRcvrCfg:
                        if (reports(rxReport, recoverySpeed))
                            nextSubstate = recoverySpeed;
                        else if (reports(rxReport, recoveryIdle))
                            nextSubstate = recoveryIdle;
                    recoverySpeed:
                        if (reports(rxReport, recoveryWait))
                            nextSubstate = recoveryWait;
                    recoveryWait:
                        if (reports(txReport, recoverySpeedEieos))
                            nextSubstate = recoverySpeedEieos;
                    recoverySpeedEieos:
                        if (reports(rxReport, recoveryRcvrLock))
                            nextSubstate = recoveryRcvrLock;
                    recoveryIdle:
                        if (reports(txReport, L0) && reports(rxReport, L0))
                            nextSubstate = L0;
                    default:
                        nextSubstate = substate;
                endcase
            end
            default:
                nextSubstate = substate;
        endcase
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            substate    <= detectQuiet;
            wasL0       <= 1'b0;
            linkUp      <= 1'b0;
            startSend16 <= 1'b0;
        end
        else if (forceDetect)
        begin
            substate    <= detectQuiet;
            wasL0       <= 1'b0;
            linkUp      <= 1'b0;
            startSend16 <= 1'b0;
        end
        else
        begin
            substate <= nextSubstate;
            wasL0    <= (substate == L0);

            if (nextSubstate == detectQuiet)
                linkUp <= 1'b0;
            else if (nextSubstate == L0)
                linkUp <= 1'b1;

            if (nextSubstate == L0 || nextSubstate == detectQuiet)
                startSend16 <= 1'b0;
            else if (substate == configurationIdle && reports(rxReport, L0))
                startSend16 <= 1'b1;
        end
    end

endmodule

// File: lpifStateMachine.sv
`timescale 1ns/10ps

module lpifStateMachine
    import ltssmPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        forceDetect,
    input  lpifState_e  lpifStateRequest,
    input  substate_e   substate,
    input  logic [7:0]  rateId,
    input  sideReport_t rxReport,
    output lpifState_e  lpifState,
    output lpifState_e  lpifStateStatus,
    output gen_t        gen,
    output gen_t        trainToGen,
    output logic        directedSpeedChange
);

    `include "ltssm_cfg.svh"

    lpifState_e nextState;
    gen_t       targetGen;
    logic       speedStart;
    logic       leftL0;

    // bit k of the rate id advertises generation k+1
    function automatic gen_t highestGen(input logic [7:0] rate);
        gen_t best;
        best = 3'd1;
        for (int k = 0; k < 5; k++)
        begin
            if (rate[k] && (k + 1) <= `LTSSM_MAX_GEN)
                best = gen_t'(k + 1);
        end
        return best;
    endfunction

    assign targetGen = highestGen(rateId);

    // upstream also waits for the partner to enter recovery
    assign speedStart = (lpifState == lpifActive) && (lpifStateRequest != lpifReset)
        && !directedSpeedChange && (targetGen > gen)
        && (`LTSSM_DEVICE_TYPE == 0
            || (rxReport.finish && rxReport.gotoState == recoveryRcvrLock));

    assign lpifStateStatus = lpifState;

    always_comb
    begin
        nextState = lpifState;
        case (lpifState)
            lpifReset:
                if (substate == L0 && lpifStateRequest == lpifActive)
                    nextState = lpifActive;
            lpifActive:
                if (lpifStateRequest == lpifReset)
                    nextState = lpifReset;
                else if (lpifStateRequest == lpifRetrain || speedStart)
                    nextState = lpifRetrain;
            lpifRetrain:
                if (substate == L0 && leftL0)
                    nextState = lpifActive;
            default:
                nextState = lpifReset;
        endcase
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            lpifState <= lpifReset;
            leftL0    <= 1'b0;
        end
        else if (forceDetect)
        begin
            lpifState <= lpifReset;
            leftL0    <= 1'b0;
        end
        else
        begin
            lpifState <= nextState;
            // retrain ends only once recovery has moved off L0
            leftL0    <= (lpifState == lpifRetrain) && (leftL0 || substate != L0);
        end
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            gen                 <= 3'd1;
            trainToGen          <= 3'd1;
            directedSpeedChange <= 1'b0;
        end
        else if (forceDetect || lpifState == lpifReset)
        begin
            gen                 <= 3'd1;
            trainToGen          <= 3'd1;
            directedSpeedChange <= 1'b0;
        end
        else if (speedStart)
        begin
            trainToGen          <= targetGen;
            directedSpeedChange <= 1'b1;
        end
        else if (substate == recoverySpeedEieos)
        begin
            gen                 <= trainToGen;
            directedSpeedChange <= 1'b0;
        end
    end

endmodule

// File: ltssmAssert.sv
`timescale 1ns/10ps

module ltssmAssert
    import ltssmPkg::*;
(
    input logic       clk,
    input logic       reset,
    input lpifState_e lpifStateStatus,
    input substate_e  substate,
    input gen_t       gen,
    input logic       linkUp,
    input logic       startSend16
);

    `include "ltssm_cfg.svh"

    // an active lpif needs a trained link
    activeNeedsLink: assert property (@(posedge clk) disable iff (!reset)
        (lpifStateStatus == lpifActive) |-> linkUp)
        else $error("lpif status active while linkUp is low");

    noSend16InL0: assert property (@(posedge clk) disable iff (!reset)
        (substate == L0) |-> !startSend16)
        else $error("startSend16 high in L0");

    genInRange: assert property (@(posedge clk) disable iff (!reset)
        gen <= `LTSSM_MAX_GEN)
        else $error("gen above the configured maximum");

endmodule

bind mainLtssm ltssmAssert u_ltssmAssert (
    .clk             (clk),
    .reset           (reset),
    .lpifStateStatus (lpifStateStatus),
    .substate        (substate),
    .gen             (gen),
    .linkUp          (linkUp),
    .startSend16     (startSend16)
);

// File: ltssmPkg.sv
`include "ltssm_cfg.svh"

package ltssmPkg;

    typedef enum logic [3:0] {
        lpifReset   = 4'd0,
        lpifActive  = 4'd1,
        lpifRetrain = 4'd11
    } lpifState_e;

    // codes 14 to 17 belong to the equalization phases, not used here
    typedef enum logic [`LTSSM_SUBSTATE_WIDTH-1:0] {
        detectQuiet                  = 0,
        detectActive                 = 1,
        pollingActive                = 2,
        pollingConfiguration         = 3,
        configurationLinkWidthStart  = 4,
        configurationLinkWidthAccept = 5,
        configurationLanenumWait     = 6,
        configurationLanenumAccept   = 7,
        configurationComplete        = 8,
        configurationIdle            = 9,
        L0                           = 10,
        recoveryRcvrLock             = 11,
        recoveryRcvrCfg              = 12,
        recoverySpeed                = 13,
        recoveryIdle                 = 18,
        recoverySpeedEieos           = 19,
        recoveryWait                 = 20
    } substate_e;

    typedef logic [2:0] gen_t;

    // one side finishing and the substate it asks for
    typedef struct packed {
        logic      finish;
        substate_e gotoState;
    } sideReport_t;

    typedef struct packed {
        logic       laneWr;
        logic [4:0] laneCount;
        logic       linkTxWr;
        logic [7:0] linkTx;
        logic       linkRxWr;
        logic [7:0] linkRx;
        logic       rateWr;
        logic [7:0] rateId;
        logic       upConfigureWr;
        logic       upConfigure;
    } paramWrite_t;

    typedef struct packed {
        logic [4:0] laneCount;
        logic [7:0] linkNumber;
        logic [7:0] rateId;
        logic       upConfigure;
    } linkParams_t;

    // width code 0, 1, 2 for 8, 16, 32 bits
    typedef struct packed {
        logic [1:0] widthCode;
        logic [4:0] pclkRate;
    } pipeCfg_t;

endpackage

// File: ltssm_cfg.svh
`ifndef LTSSM_CFG_SVH
`define LTSSM_CFG_SVH

// highest generation the link may train to
`define LTSSM_MAX_GEN 3

// 0 downstream port, 1 upstream port
`define LTSSM_DEVICE_TYPE 0

// pipe data width in bits per generation, 8, 16 or 32
`define LTSSM_GEN1_PIPE_WIDTH 8
`define LTSSM_GEN2_PIPE_WIDTH 8
`define LTSSM_GEN3_PIPE_WIDTH 16
`define LTSSM_GEN4_PIPE_WIDTH 16
`define LTSSM_GEN5_PIPE_WIDTH 32

// substate encoding width
`define LTSSM_SUBSTATE_WIDTH 5

`endif

// File: mainLtssm.sv
`timescale 1ns/10ps

module mainLtssm
    import ltssmPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        forceDetect,
    input  lpifState_e  lpifStateRequest,
    input  sideReport_t txReport,
    input  sideReport_t rxReport,
    input  paramWrite_t paramWr,
    output linkParams_t params,
    output lpifState_e  lpifStateStatus,
    output substate_e   substate,
    output gen_t        gen,
    output gen_t        trainToGen,
    output logic        directedSpeedChange,
    output logic        linkUp,
    output logic        startSend16,
    output pipeCfg_t    pipeCfg
);

    lpifState_e lpifState;

    linkParamRegs u_linkParamRegs (
        .clk         (clk),
        .reset       (reset),
        .forceDetect (forceDetect),
        .wr          (paramWr),
        .params      (params)
    );

    linkStateSequencer u_linkStateSequencer (
        .clk         (clk),
        .reset       (reset),
        .forceDetect (forceDetect),
        .lpifState   (lpifState),
        .txReport    (txReport),
        .rxReport    (rxReport),
        .substate    (substate),
        .linkUp      (linkUp),
        .startSend16 (startSend16)
    );

    lpifStateMachine u_lpifStateMachine (
        .clk                 (clk),
        .reset               (reset),
        .forceDetect         (forceDetect),
        .lpifStateRequest    (lpifStateRequest),
        .substate            (substate),
        .rateId              (params.rateId),
        .rxReport            (rxReport),
        .lpifState           (lpifState),
        .lpifStateStatus     (lpifStateStatus),
        .gen                 (gen),
        .trainToGen          (trainToGen),
        .directedSpeedChange (directedSpeedChange)
    );

    pipeRateMap u_pipeRateMap (
        .clk         (clk),
        .reset       (reset),
        .forceDetect (forceDetect),
        .gen         (gen),
        .pipeCfg     (pipeCfg)
    );

endmodule

// File: pipeRateMap.sv
`timescale 1ns/10ps

module pipeRateMap
    import ltssmPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     forceDetect,
    input  gen_t     gen,
    output pipeCfg_t pipeCfg
);

    `include "ltssm_cfg.svh"

    function automatic logic [1:0] codeForWidth(input int bits);
        case (bits)
            16:      return 2'd1;
            32:      return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

    // pclk halves for every doubling of the pipe width
    function automatic pipeCfg_t mapGen(input gen_t g);
        int       bits;
        pipeCfg_t cfg;
        case (g)
            3'd2:    bits = `LTSSM_GEN2_PIPE_WIDTH;
            3'd3:    bits = `LTSSM_GEN3_PIPE_WIDTH;
            3'd4:    bits = `LTSSM_GEN4_PIPE_WIDTH;
            3'd5:    bits = `LTSSM_GEN5_PIPE_WIDTH;
            default: bits = `LTSSM_GEN1_PIPE_WIDTH;
        endcase
        cfg.widthCode = codeForWidth(bits);
        cfg.pclkRate  = {2'b00, g} + 5'd1 - {3'b000, cfg.widthCode};
        return cfg;
    endfunction

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            pipeCfg <= mapGen(3'd1);
        else if (forceDetect)
            pipeCfg <= mapGen(3'd1);
        else
            pipeCfg <= mapGen(gen);
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module tbMainLtssm -o simMainLtssm

status=0
./obj_dir/simMainLtssm > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation clean"

// File: tbMainLtssm.sv
`timescale 1ns/10ps

module tbMainLtssm
    import ltssmPkg::*;
();

    `include "ltssm_cfg.svh"

    localparam int stepCount = 80;
    localparam int cyclesPerStep = 40;
    localparam sideReport_t noReport = '0;

    logic        clk;
    logic        reset;
    logic        forceDetect;
    lpifState_e  lpifStateRequest;
    sideReport_t txReport;
    sideReport_t rxReport;
    paramWrite_t paramWr;
    linkParams_t params;
    lpifState_e  lpifStateStatus;
    substate_e   substate;
    gen_t        gen;
    gen_t        trainToGen;
    logic        directedSpeedChange;
    logic        linkUp;
    logic        startSend16;
    pipeCfg_t    pipeCfg;

    int          mismatchCount;
    int          timeoutCount;
    linkParams_t expectedParams;

    mainLtssm dut (
        .clk                 (clk),
        .reset               (reset),
        .forceDetect         (forceDetect),
        .lpifStateRequest    (lpifStateRequest),
        .txReport            (txReport),
        .rxReport            (rxReport),
        .paramWr             (paramWr),
        .params              (params),
        .lpifStateStatus     (lpifStateStatus),
        .substate            (substate),
        .gen                 (gen),
        .trainToGen          (trainToGen),
        .directedSpeedChange (directedSpeedChange),
        .linkUp              (linkUp),
        .startSend16         (startSend16),
        .pipeCfg             (pipeCfg)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected)
        begin
            mismatchCount++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    function automatic sideReport_t reportOf(input substate_e s);
        sideReport_t r;
        r.finish    = 1'b1;
        r.gotoState = s;
        return r;
    endfunction

    // width code is the pipe width over 16
    // rate code is gen plus 1 minus the width code
    function automatic logic [31:0] expectedPipeCfg(input int g);
        int bits;
        int code;
        case (g)
            2:       bits = `LTSSM_GEN2_PIPE_WIDTH;
            3:       bits = `LTSSM_GEN3_PIPE_WIDTH;
            4:       bits = `LTSSM_GEN4_PIPE_WIDTH;
            5:       bits = `LTSSM_GEN5_PIPE_WIDTH;
            default: bits = `LTSSM_GEN1_PIPE_WIDTH;
        endcase
        code = bits / 16;
        return 32'({code[1:0], 5'(g + 1 - code)});
    endfunction

    // reports are held for one cycle, sampled on the following edge
    task automatic sendReports(input sideReport_t tx, input sideReport_t rx);
        @(posedge clk);
        txReport <= tx;
        rxReport <= rx;
        @(posedge clk);
        txReport <= noReport;
        rxReport <= noReport;
        @(negedge clk);
    endtask

    task automatic advance(input sideReport_t tx, input sideReport_t rx,
                           input substate_e expected);
        sendReports(tx, rx);
        checkValue("substate", 32'(substate), 32'(expected));
    endtask

    task automatic waitForSubstate(input substate_e s);
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (substate != s && n < cyclesPerStep);
        if (substate != s)
        begin
            timeoutCount++;
            $display("substate never reached %s within %0d cycles", s.name(), cyclesPerStep);
        end
    endtask

    task automatic waitForStatus(input lpifState_e st);
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (lpifStateStatus != st && n < cyclesPerStep);
        if (lpifStateStatus != st)
        begin
            timeoutCount++;
            $display("lpif status never reached %s within %0d cycles", st.name(), cyclesPerStep);
        end
    endtask

    task automatic writeParams(input paramWrite_t w);
        @(posedge clk);
        paramWr <= w;
        @(posedge clk);
        paramWr <= '0;
        @(negedge clk);
    endtask

    task automatic checkIdle(input logic withParams);
        checkValue("substate", 32'(substate), 32'(detectQuiet));
        checkValue("lpif status", 32'(lpifStateStatus), 32'(lpifReset));
        checkValue("gen", 32'(gen), 32'd1);
        checkValue("trainToGen", 32'(trainToGen), 32'd1);
        checkValue("directedSpeedChange", 32'(directedSpeedChange), 32'd0);
        checkValue("linkUp", 32'(linkUp), 32'd0);
        checkValue("startSend16", 32'(startSend16), 32'd0);
        checkValue("pipeCfg", 32'(pipeCfg), expectedPipeCfg(1));
        if (withParams)
            checkValue("params", 32'(params), 32'(expectedParams));
    endtask

    task automatic randomParamWrites();
        paramWrite_t w;
        for (int i = 0; i < 6; i++)
        begin
            w.laneWr        = 1'($urandom);
            w.laneCount     = 5'($urandom);
            w.linkTxWr      = 1'($urandom);
            w.linkTx        = 8'($urandom);
            w.linkRxWr      = 1'($urandom);
            w.linkRx        = 8'($urandom);
            w.rateWr        = 1'($urandom);
            w.rateId        = 8'($urandom);
            w.upConfigureWr = 1'($urandom);
            w.upConfigure   = 1'($urandom);
            // last round forces both link writes with different values
            if (i == 5)
            begin
                w.linkTxWr = 1'b1;
                w.linkRxWr = 1'b1;
                w.linkRx   = ~w.linkTx;
            end
            if (w.laneWr)
                expectedParams.laneCount = w.laneCount;
            if (w.linkTxWr)
                expectedParams.linkNumber = w.linkTx;
            else if (w.linkRxWr)
                expectedParams.linkNumber = w.linkRx;
            if (w.rateWr)
                expectedParams.rateId = w.rateId;
            if (w.upConfigureWr)
                expectedParams.upConfigure = w.upConfigure;
            writeParams(w);
            checkValue("params", 32'(params), 32'(expectedParams));
        end
        // a gen 1 rate id keeps training free of a speed change
        w = '0;
        w.rateWr = 1'b1;
        w.rateId = 8'h01;
        expectedParams.rateId = 8'h01;
        writeParams(w);
        checkValue("params", 32'(params), 32'(expectedParams));
    endtask

    task automatic quietReturnInConfig();
        advance(noReport, reportOf(detectActive), detectActive);
        // one side alone does not leave detect active
        advance(reportOf(pollingActive), noReport, detectActive);
        advance(reportOf(pollingActive), reportOf(pollingActive), pollingActive);
        advance(reportOf(pollingConfiguration), noReport, pollingConfiguration);
        advance(reportOf(configurationLinkWidthStart), reportOf(configurationLinkWidthStart),
                configurationLinkWidthStart);
        // forward move beats the quiet report
        advance(reportOf(detectQuiet), reportOf(configurationLinkWidthAccept),
                configurationLinkWidthAccept);
        advance(noReport, reportOf(detectQuiet), detectQuiet);
        checkValue("linkUp", 32'(linkUp), 32'd0);
    endtask

    task automatic trainLink();
        advance(noReport, reportOf(detectActive), detectActive);
        advance(reportOf(pollingActive), reportOf(pollingActive), pollingActive);
        advance(noReport, reportOf(pollingConfiguration), pollingConfiguration);
        advance(reportOf(configurationLinkWidthStart), reportOf(configurationLinkWidthStart),
                configurationLinkWidthStart);
        advance(noReport, reportOf(configurationLinkWidthAccept), configurationLinkWidthAccept);
        advance(reportOf(configurationLanenumWait), noReport, configurationLanenumWait);
        advance(noReport, reportOf(configurationLanenumAccept), configurationLanenumAccept);
        advance(noReport, reportOf(configurationComplete), configurationComplete);
        advance(reportOf(configurationIdle), reportOf(configurationIdle), configurationIdle);
        checkValue("startSend16", 32'(startSend16), 32'd0);
        advance(noReport, reportOf(L0), configurationIdle);
        checkValue("startSend16", 32'(startSend16), 32'd1);
        checkValue("linkUp", 32'(linkUp), 32'd0);
        advance(reportOf(L0), noReport, L0);
        checkValue("startSend16", 32'(startSend16), 32'd0);
        checkValue("linkUp", 32'(linkUp), 32'd1);
        @(negedge clk);
        checkValue("lpif status", 32'(lpifStateStatus), 32'(lpifActive));
    endtask

    task automatic trainWithActiveRequest();
        @(posedge clk);
        lpifStateRequest <= lpifActive;
        trainLink();
        checkValue("gen", 32'(gen), 32'd1);
        checkValue("trainToGen", 32'(trainToGen), 32'd1);
    endtask

    task automatic speedChangeToGen3();
        paramWrite_t w;
        w = '0;
        w.rateWr = 1'b1;
        w.rateId = 8'h07;
        expectedParams.rateId = 8'h07;
        checkValue("pipeCfg", 32'(pipeCfg), expectedPipeCfg(1));
        writeParams(w);
        waitForStatus(lpifRetrain);
        checkValue("trainToGen", 32'(trainToGen), 32'd3);
        checkValue("directedSpeedChange", 32'(directedSpeedChange), 32'd1);
        checkValue("gen", 32'(gen), 32'd1);
        waitForSubstate(recoveryRcvrLock);
        advance(noReport, reportOf(recoveryRcvrCfg), recoveryRcvrCfg);
        advance(noReport, reportOf(recoverySpeed), recoverySpeed);
        advance(noReport, reportOf(recoveryWait), recoveryWait);
        advance(reportOf(recoverySpeedEieos), noReport, recoverySpeedEieos);
        checkValue("gen", 32'(gen), 32'd1);
        @(negedge clk);
        checkValue("gen", 32'(gen), 32'd3);
        checkValue("directedSpeedChange", 32'(directedSpeedChange), 32'd0);
        @(negedge clk);
        checkValue("pipeCfg", 32'(pipeCfg), expectedPipeCfg(3));
        advance(noReport, reportOf(recoveryRcvrLock), recoveryRcvrLock);
        advance(noReport, reportOf(recoveryRcvrCfg), recoveryRcvrCfg);
        advance(noReport, reportOf(recoveryIdle), recoveryIdle);
        advance(reportOf(L0), reportOf(L0), L0);
        waitForStatus(lpifActive);
        checkValue("gen", 32'(gen), 32'd3);
        checkValue("linkUp", 32'(linkUp), 32'd1);
    endtask

    task automatic retrainThroughIdle();
        @(posedge clk);
        lpifStateRequest <= lpifRetrain;
        @(posedge clk);
        lpifStateRequest <= lpifActive;
        waitForSubstate(recoveryRcvrLock);
        checkValue("lpif status", 32'(lpifStateStatus), 32'(lpifRetrain));
        checkValue("directedSpeedChange", 32'(directedSpeedChange), 32'd0);
        advance(noReport, reportOf(recoveryRcvrCfg), recoveryRcvrCfg);
        advance(noReport, reportOf(recoveryIdle), recoveryIdle);
        advance(reportOf(L0), reportOf(L0), L0);
        waitForStatus(lpifActive);
        checkValue("gen", 32'(gen), 32'd3);
        checkValue("trainToGen", 32'(trainToGen), 32'd3);
        checkValue("pipeCfg", 32'(pipeCfg), expectedPipeCfg(3));
    endtask

    task automatic resetAndForceDetect();
        @(posedge clk);
        lpifStateRequest <= lpifReset;
        waitForSubstate(detectQuiet);
        // pipe codes trail gen by a cycle
        @(negedge clk);
        checkIdle(1'b0);
        @(posedge clk);
        lpifStateRequest <= lpifActive;
        trainLink();
        @(posedge clk);
        forceDetect <= 1'b1;
        @(posedge clk);
        forceDetect <= 1'b0;
        @(negedge clk);
        expectedParams = '0;
        checkIdle(1'b1);
    endtask

    initial
    begin
        int seedValue;
        mismatchCount    = 0;
        timeoutCount     = 0;
        expectedParams   = '0;
        seedValue        = $urandom(46);
        reset            = 1'b0;
        forceDetect      = 1'b0;
        lpifStateRequest = lpifReset;
        txReport         = noReport;
        rxReport         = noReport;
        paramWr          = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        checkIdle(1'b1);

        randomParamWrites();
        quietReturnInConfig();
        trainWithActiveRequest();
        speedChangeToGen3();
        retrainThroughIdle();
        resetAndForceDetect();

        $display("checks failed: %0d, waits timed out: %0d", mismatchCount, timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // watchdog sized on the number of test steps
    initial
    begin
        repeat (stepCount * cyclesPerStep) @(posedge clk);
        $display("timeout: the tests ran longer than %0d cycles", stepCount * cyclesPerStep);
        $display("sim failed");
        $finish;
    end

endmodule
